/* Bender.yml */
package:
  name: mbc_cart

sources:
  - include_dirs:
      - design
    files:
      - design/mbc_pkg.sv
      - design/mbc_header_decode.sv
      - design/mbc_bank_regs.sv
      - design/mbc_addr_map.sv
      - design/cart_ram.sv
      - design/mbc_cart.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - verif/mbc_cart_tb.sv

/* design/cart_ram.sv */
`include "mbc_consts.svh"

module cart_ram (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic [`MBC_RAM_ADDR_W-1:0] cram_addr,
	input  logic                       cram_rd,
	input  logic                       cram_wr,
	input  logic [7:0]                 cram_di,
	input  logic                       nibble_ram,
	input  logic                       rtc_sel,
	input  logic                       ram_en,
	output logic [7:0]                 cram_do,
	output logic                       cram_valid
);

	logic [7:0] mem [0:(1 << `MBC_RAM_ADDR_W)-1]; // 16 banks of 8k
	logic [7:0] rd_q;
	logic       nibble_q;
	logic       rtc_q;
	logic       en_q;

	// ------------------------------------------------------------
	// array and read register
	// ------------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (cram_wr)
			mem[cram_addr] <= cram_di; // lands even while ram is locked
		if (cram_rd) begin
			rd_q     <= mem[cram_addr];
			nibble_q <= nibble_ram;
			rtc_q    <= rtc_sel;
			en_q     <= ram_en;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			cram_valid <= 1'b0;
		else
			cram_valid <= cram_rd;
	end

	// read data as the cpu sees it
	always_comb begin
		if (!en_q)
			cram_do = `CRAM_OPEN_BUS;
		else if (nibble_q)
			cram_do = {4'hF, rd_q[3:0]}; // mbc2 stores 4 bits, upper nibble floats high
		else if (rtc_q)
			cram_do = 8'h00; // no clock behind the rtc registers
		else
			cram_do = rd_q;
	end

	// an unknown bank or offset would hit no cell at all
	assert property (@(posedge clk_sys) disable iff (reset)
		(cram_rd || cram_wr) |-> !$isunknown(cram_addr));

endmodule

/* design/mbc_addr_map.sv */
`include "mbc_consts.svh"

module mbc_addr_map (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  mbc_pkg::cart_addr_u        cart_addr,
	input  logic                       cart_rd,
	input  logic                       cart_wr,
	input  logic [7:0]                 cart_di,
	input  logic                       is_mbc1,
	input  logic                       is_mbc2,
	input  logic                       is_mbc3,
	input  logic                       is_mbc5,
	input  logic [`MBC_ROM_BANK_W-1:0] rom_mask,
	input  logic [`MBC_RAM_BANK_W-1:0] ram_mask,
	input  logic [`MBC_ROM_BANK_W-1:0] rom_bank_reg,
	input  logic [`MBC_RAM_BANK_W-1:0] ram_bank_reg,
	input  logic                       mbc1_mode,
	input  logic                       rtc_mode,
	input  logic                       ram_enable,
	output logic [`MBC_ROM_ADDR_W-1:0] rom_addr,
	output logic [`MBC_RAM_ADDR_W-1:0] cram_addr,
	output logic                       cram_rd,
	output logic                       cram_wr,
	output logic [7:0]                 cram_di,
	output logic                       nibble_ram,
	output logic                       rtc_sel,
	output logic                       ram_en
);

	logic [`MBC_ROM_BANK_W:0]   rom_page; // 8k rom page number
	logic [`MBC_RAM_BANK_W-1:0] ram_bank;
	logic [6:0]                 mbc1_bank; // mode 0 puts ram bank bits on rom a20:a19
	logic                       is_cram;
	logic                       nibble_hit;

	// ------------------------------------------------------------
	// rom page
	// ------------------------------------------------------------

	assign mbc1_bank = {mbc1_mode ? 2'b00 : ram_bank_reg[1:0], rom_bank_reg[4:0]} & rom_mask[6:0];

	always_comb begin
		if (!(is_mbc1 || is_mbc2 || is_mbc3 || is_mbc5))
			rom_page = {8'd0, cart_addr.rom.region[0], cart_addr.rom.half}; // flat 32k
		else if (cart_addr.rom.region == `ROM_REGION_BANK0)
			rom_page = {9'd0, cart_addr.rom.half};
		else if (cart_addr.rom.region == `ROM_REGION_BANKN) begin
			if (is_mbc1)
				rom_page = {2'b00, mbc1_bank, cart_addr.rom.half};
			else if (is_mbc5)
				rom_page = {rom_bank_reg & rom_mask, cart_addr.rom.half};
			else // mbc2 only decodes 16 banks, the mask trims it
				rom_page = {2'b00, rom_bank_reg[6:0] & rom_mask[6:0], cart_addr.rom.half};
		end else
			rom_page = '0; // ram and io area
	end

	// ------------------------------------------------------------
	// ram bank and window flags
	// ------------------------------------------------------------

	always_comb begin
		if (is_mbc1)
			ram_bank = mbc1_mode ? {2'b00, ram_bank_reg[1:0]} : '0;
		else if (is_mbc3)
			ram_bank = {2'b00, ram_bank_reg[1:0]};
		else if (is_mbc5)
			ram_bank = ram_bank_reg;
		else
			ram_bank = '0;
		ram_bank = ram_bank & ram_mask; // mirror small rams
	end

	assign is_cram    = (cart_addr.ram.region == `REGION_CRAM);
	assign nibble_hit = is_mbc2 &&
		({cart_addr.ram.region, cart_addr.ram.offset[12:9]} == `MBC2_RAM_PAGE);

	// ------------------------------------------------------------
	// output register
	// ------------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		rom_addr   <= {1'b0, rom_page, cart_addr.rom.offset};
		cram_addr  <= {ram_bank, cart_addr.ram.offset};
		cram_di    <= cart_di;
		nibble_ram <= nibble_hit;
		rtc_sel    <= rtc_mode && !nibble_hit;
		ram_en     <= ram_enable;
		if (reset) begin
			cram_rd <= 1'b0;
			cram_wr <= 1'b0;
		end else begin
			cram_rd <= cart_rd && is_cram; // only a000-bfff reaches the ram
			cram_wr <= cart_wr && is_cram;
		end
	end

	// the cpu bus never drives both strobes, the ram port relies on it
	assert property (@(posedge clk_sys) disable iff (reset) !(cart_rd && cart_wr));

endmodule

/* design/mbc_bank_regs.sv */
`include "mbc_consts.svh"

module mbc_bank_regs (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  mbc_pkg::cart_addr_u        cart_addr,
	input  logic                       cart_wr,
	input  logic [7:0]                 cart_di,
	input  logic                       is_mbc1,
	input  logic                       is_mbc3,
	input  logic                       is_mbc5,
	output logic [`MBC_ROM_BANK_W-1:0] rom_bank_reg,
	output logic [`MBC_RAM_BANK_W-1:0] ram_bank_reg,
	output logic                       mbc1_mode,
	output logic                       rtc_mode,
	output logic                       ram_enable
);

	// ------------------------------------------------------------
	// cpu writes into the rom area land here
	// ------------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_bank_reg <= `MBC_ROM_BANK_W'(`ROM_BANK_RESET);
			ram_bank_reg <= '0;
			mbc1_mode    <= 1'b0;
			rtc_mode     <= 1'b0;
			ram_enable   <= 1'b0;
		end else if (cart_wr) begin
			case (cart_addr.ram.region)
				`REGION_RAM_EN: ram_enable <= (cart_di[3:0] == `RAM_EN_KEY); // any other value locks
				`REGION_ROM_BANK: begin
					if (is_mbc5) begin
						// 3000-3fff carries bank bit 8, 2000-2fff the low byte
						if (cart_addr.ram.offset[12])
							rom_bank_reg[`MBC_ROM_BANK_W-1] <= cart_di[0];
						else
							rom_bank_reg[`MBC_ROM_BANK_W-2:0] <= cart_di;
					end else if (cart_di[6:0] == 7'd0) begin
						rom_bank_reg <= `MBC_ROM_BANK_W'(`ROM_BANK_RESET); // 0 reads as 1
					end else begin
						rom_bank_reg <= {2'b00, cart_di[6:0]};
					end
				end
				`REGION_RAM_BANK: begin
					if (is_mbc3) begin
						rtc_mode <= cart_di[3]; // 08-0c pick an rtc register
						if (!cart_di[3])
							ram_bank_reg <= {2'b00, cart_di[1:0]};
					end else if (is_mbc5) begin
						ram_bank_reg <= cart_di[3:0];
					end else begin
						ram_bank_reg <= {2'b00, cart_di[1:0]}; // mbc1 upper bits
					end
				end
				`REGION_MODE: begin
					if (is_mbc1)
						mbc1_mode <= cart_di[0]; // 1 = 4 mb rom / 32 kb ram mode
				end
				default: ;
			endcase
		end
	end

	// x on a written address or byte would scramble the bank state
	assert property (@(posedge clk_sys) disable iff (reset)
		cart_wr |-> !$isunknown({cart_addr, cart_di}));

endmodule

/* design/mbc_cart.sv */
`include "mbc_consts.svh"

module mbc_cart (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic [7:0]                 cart_mbc_type,
	input  logic [7:0]                 cart_rom_size,
	input  logic [7:0]                 cart_ram_size,
	input  mbc_pkg::cart_addr_u        cart_addr,
	input  logic                       cart_rd,
	input  logic                       cart_wr,
	input  logic [7:0]                 cart_di,
	output logic [`MBC_ROM_ADDR_W-1:0] rom_addr,
	output logic [7:0]                 cram_do,
	output logic                       cram_valid
);

	// header decode
	logic                       is_mbc1;
	logic                       is_mbc2;
	logic                       is_mbc3;
	logic                       is_mbc5;
	logic [`MBC_ROM_BANK_W-1:0] rom_mask;
	logic [`MBC_RAM_BANK_W-1:0] ram_mask;

	// bank registers
	logic [`MBC_ROM_BANK_W-1:0] rom_bank_reg;
	logic [`MBC_RAM_BANK_W-1:0] ram_bank_reg;
	logic                       mbc1_mode;
	logic                       rtc_mode;
	logic                       ram_enable;

	// address map to ram
	logic [`MBC_RAM_ADDR_W-1:0] cram_addr;
	logic                       cram_rd;
	logic                       cram_wr;
	logic [7:0]                 cram_di;
	logic                       nibble_ram;
	logic                       rtc_sel;
	logic                       ram_en;

	mbc_header_decode header_decode_inst (.cart_mbc_type, .cart_rom_size, .cart_ram_size,
		.is_mbc1, .is_mbc2, .is_mbc3, .is_mbc5, .rom_mask, .ram_mask);

	mbc_bank_regs bank_regs_inst (.clk_sys, .reset, .cart_addr, .cart_wr, .cart_di,
		.is_mbc1, .is_mbc3, .is_mbc5,
		.rom_bank_reg, .ram_bank_reg, .mbc1_mode, .rtc_mode, .ram_enable);

	mbc_addr_map addr_map_inst (.clk_sys, .reset, .cart_addr, .cart_rd, .cart_wr, .cart_di,
		.is_mbc1, .is_mbc2, .is_mbc3, .is_mbc5, .rom_mask, .ram_mask,
		.rom_bank_reg, .ram_bank_reg, .mbc1_mode, .rtc_mode, .ram_enable,
		.rom_addr, .cram_addr, .cram_rd, .cram_wr, .cram_di, .nibble_ram, .rtc_sel, .ram_en);

	cart_ram cart_ram_inst (.clk_sys, .reset, .cram_addr, .cram_rd, .cram_wr, .cram_di,
		.nibble_ram, .rtc_sel, .ram_en, .cram_do, .cram_valid);

endmodule

/* design/mbc_consts.svh */
`ifndef MBC_CONSTS_SVH
`define MBC_CONSTS_SVH

// ------------------------------------------------------------
// widths
// ------------------------------------------------------------

`define MBC_ROM_ADDR_W 24 // 16 mb rom window
`define MBC_RAM_ADDR_W 17 // 128 kb cart ram
`define MBC_ROM_BANK_W 9  // up to 512 banks of 16k (mbc5)
`define MBC_RAM_BANK_W 4  // up to 16 banks of 8k

// ------------------------------------------------------------
// 8k address regions, a15:a13
// ------------------------------------------------------------

`define REGION_RAM_EN   3'd0 // 0000-1fff
`define REGION_ROM_BANK 3'd1 // 2000-3fff
`define REGION_RAM_BANK 3'd2 // 4000-5fff, also rtc select on mbc3
`define REGION_MODE     3'd3 // 6000-7fff, mbc1 banking mode
`define REGION_CRAM     3'd5 // a000-bfff

// 16k rom regions, a15:a14
`define ROM_REGION_BANK0 2'd0 // fixed bank 0
`define ROM_REGION_BANKN 2'd1 // switchable bank

// ------------------------------------------------------------
// register values
// ------------------------------------------------------------

`define RAM_EN_KEY     4'hA  // low nibble written to region 0 to unlock ram
`define MBC2_RAM_PAGE  7'h50 // a15:a9 of the 512 x 4 bit mbc2 ram, a000-a1ff
`define ROM_BANK_RESET 1     // bank 0 can not be mapped at 4000 on mbc1-3
`define CRAM_OPEN_BUS  8'hFF // read value with ram locked

// ------------------------------------------------------------
// mask tables
// ------------------------------------------------------------

`define ROM_MASK_ODD   9'h07F // 72/80/96 bank carts, rounded up to 128
`define RAM_MASK_NONE  4'h0   // 2k or 8k, a single bank
`define RAM_MASK_4BANK 4'h3   // 32k
`define RAM_MASK_ALL   4'hF   // 128k

`endif

/* design/mbc_header_decode.sv */
`include "mbc_consts.svh"

module mbc_header_decode (
	input  logic [7:0]                 cart_mbc_type, // header byte 0x147
	input  logic [7:0]                 cart_rom_size, // header byte 0x148
	input  logic [7:0]                 cart_ram_size, // header byte 0x149
	output logic                       is_mbc1,
	output logic                       is_mbc2,
	output logic                       is_mbc3,
	output logic                       is_mbc5,
	output logic [`MBC_ROM_BANK_W-1:0] rom_mask,
	output logic [`MBC_RAM_BANK_W-1:0] ram_mask
);

	// ------------------------------------------------------------
	// controller kind
	// ------------------------------------------------------------

	always_comb begin
		is_mbc1 = 1'b0;
		is_mbc2 = 1'b0;
		is_mbc3 = 1'b0;
		is_mbc5 = 1'b0;
		case (cart_mbc_type)
			8'h01, 8'h02, 8'h03:               is_mbc1 = 1'b1; // plain, +ram, +ram+batt
			8'h05, 8'h06:                      is_mbc2 = 1'b1; // built in nibble ram
			8'h0F, 8'h10, 8'h11, 8'h12, 8'h13: is_mbc3 = 1'b1; // with and without timer
			8'h19, 8'h1A, 8'h1B:               is_mbc5 = 1'b1;
			8'h1C, 8'h1D, 8'h1E:               is_mbc5 = 1'b1; // rumble variants
			default: ; // rom only, mmm01, mbc4, huc and unknown codes
		endcase
	end

	// ------------------------------------------------------------
	// size masks for bank mirroring
	// ------------------------------------------------------------

	always_comb begin
		case (cart_rom_size)
			// 2 << n banks, so n + 1 low ones
			8'h00, 8'h01, 8'h02, 8'h03, 8'h04, 8'h05, 8'h06, 8'h07, 8'h08:
				rom_mask = {`MBC_ROM_BANK_W{1'b1}} >> (4'd8 - cart_rom_size[3:0]);
			default: rom_mask = `ROM_MASK_ODD; // 52-54 odd sizes, junk treated as 2 mb
		endcase
	end

	always_comb begin
		case (cart_ram_size)
			8'h00, 8'h01, 8'h02: ram_mask = `RAM_MASK_NONE; // none, 2k, 8k
			8'h03:               ram_mask = `RAM_MASK_4BANK;
			default:             ram_mask = `RAM_MASK_ALL;   // 128k and above
		endcase
	end

endmodule

/* design/mbc_pkg.sv */
package mbc_pkg;

	// ------------------------------------------------------------
	// cpu cartridge address, seen by the rom map and the ram map
	// ------------------------------------------------------------

	// rom side: 16k regions, each split in two 8k halves
	typedef struct packed {
		logic [1:0]  region; // a15:a14, 0 = fixed bank, 1 = switchable bank
		logic        half;   // a13, low bit of the 8k rom page
		logic [12:0] offset; // byte within the 8k page
	} cart_rom_view_t;

	// register / ram side: eight 8k regions
	typedef struct packed {
		logic [2:0]  region; // a15:a13
		logic [12:0] offset; // a12 also splits the mbc5 bank register
	} cart_ram_view_t;

	// both views cover all 16 address bits
	typedef union packed {
		cart_rom_view_t rom;
		cart_ram_view_t ram;
	} cart_addr_u;

endpackage

/* mbc_cart.f */
+incdir+design
design/mbc_pkg.sv
design/mbc_header_decode.sv
design/mbc_bank_regs.sv
design/mbc_addr_map.sv
design/cart_ram.sv
design/mbc_cart.sv
verif/mbc_cart_tb.sv

/* verif/mbc_cart_tb.sv */
`include "mbc_consts.svh"

module mbc_cart_tb;

	localparam int kind_none = 0;
	localparam int kind_mbc1 = 1;
	localparam int kind_mbc2 = 2;
	localparam int kind_mbc3 = 3;
	localparam int kind_mbc5 = 4;

	logic        clk_sys;
	logic        reset;
	logic [7:0]  cart_mbc_type;
	logic [7:0]  cart_rom_size;
	logic [7:0]  cart_ram_size;
	logic [15:0] cart_addr; // cpu address, the dut splits it two ways
	logic        cart_rd;
	logic        cart_wr;
	logic [7:0]  cart_di;
	logic [23:0] rom_addr;
	logic [7:0]  cram_do;
	logic        cram_valid;

	// reference model state
	logic [31:0] lfsr = 32'h53d4;
	int          errors = 0;
	int          checks = 0;
	int          cyc = 0; // drive cycles, ages pending reads
	int          kind;
	logic [8:0]  model_rom_mask;
	logic [3:0]  model_ram_mask;
	logic [8:0]  model_rom_bank;
	logic [3:0]  model_ram_bank;
	logic        model_mode;
	logic        model_rtc;
	logic        model_ram_en;
	logic [7:0]  model_mem [0:131071];
	logic [23:0] rom_q [$];   // expected rom_addr, one per drive cycle
	logic [7:0]  rd_q [$];    // expected read data in issue order
	int          age_q [$];   // issue cycle of each pending read
	logic [15:0] written_q [$]; // recent ram write addresses to read back

	mbc_cart mbc_cart_inst (.clk_sys, .reset, .cart_mbc_type, .cart_rom_size, .cart_ram_size,
		.cart_addr, .cart_rd, .cart_wr, .cart_di, .rom_addr, .cram_do, .cram_valid);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------

	// galois lfsr, one step per bit handed out
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic compare(input logic [31:0] expected, input logic [31:0] actual,
		input string name);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("mismatch %0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	function automatic logic [23:0] rom_model(input logic [15:0] a);
		logic [9:0] page; // 8k page
		logic [6:0] low;
		low = {model_mode ? 2'b00 : model_ram_bank[1:0], model_rom_bank[4:0]};
		if (kind == kind_none)
			page = {8'd0, a[14:13]}; // plain 32k rom
		else if (a[15:14] == 2'd0)
			page = {9'd0, a[13]};
		else if (a[15:14] == 2'd1) begin
			if (kind == kind_mbc1)
				page = {2'b00, low & model_rom_mask[6:0], a[13]};
			else if (kind == kind_mbc5)
				page = {model_rom_bank & model_rom_mask, a[13]};
			else
				page = {2'b00, model_rom_bank[6:0] & model_rom_mask[6:0], a[13]};
		end else
			page = 10'd0;
		return {1'b0, page, a[12:0]};
	endfunction

	function automatic logic [16:0] ram_index(input logic [15:0] a);
		logic [3:0] bank;
		case (kind)
			kind_mbc1: bank = model_mode ? {2'b00, model_ram_bank[1:0]} : 4'd0;
			kind_mbc3: bank = {2'b00, model_ram_bank[1:0]};
			kind_mbc5: bank = model_ram_bank;
			default:   bank = 4'd0;
		endcase
		return {bank & model_ram_mask, a[12:0]};
	endfunction

	function automatic logic [7:0] read_model(input logic [15:0] a);
		logic [7:0] b;
		b = model_mem[ram_index(a)];
		if (!model_ram_en)
			return 8'hFF; // locked
		if (kind == kind_mbc2 && a[15:9] == `MBC2_RAM_PAGE)
			return {4'hF, b[3:0]};
		if (model_rtc)
			return 8'h00;
		return b;
	endfunction

	task automatic write_model(input logic [15:0] a, input logic [7:0] d);
		case (a[15:13])
			3'd0: model_ram_en = (d[3:0] == `RAM_EN_KEY);
			3'd1: begin
				if (kind == kind_mbc5 && a[12])
					model_rom_bank[8] = d[0];
				else if (kind == kind_mbc5)
					model_rom_bank[7:0] = d;
				else
					model_rom_bank = (d[6:0] == 7'd0) ? 9'd1 : {2'b00, d[6:0]};
			end
			3'd2: begin
				if (kind == kind_mbc3) begin
					model_rtc = d[3];
					if (!d[3])
						model_ram_bank = {2'b00, d[1:0]};
				end else
					model_ram_bank = (kind == kind_mbc5) ? d[3:0] : {2'b00, d[1:0]};
			end
			3'd3: if (kind == kind_mbc1) model_mode = d[0];
			3'd5: model_mem[ram_index(a)] = d; // lands even while locked
			default: ;
		endcase
	endtask

	// outputs settled since the last rising edge
	task automatic check_outputs();
		if (rom_q.size() > 0)
			compare(rom_q.pop_front(), rom_addr, "rom_addr");
		if (cram_valid) begin
			if (rd_q.size() == 0) begin
				errors++;
				$display("cram_valid went high at %0t with no read pending", $time);
			end else begin
				compare(2, cyc - age_q.pop_front(), "cram_valid latency");
				compare(rd_q.pop_front(), cram_do, "cram_do");
			end
		end else if (age_q.size() > 0 && cyc - age_q[0] > 3) begin
			errors++;
			$display("read issued in cycle %0d never returned, at %0t", age_q[0], $time);
			void'(age_q.pop_front());
			void'(rd_q.pop_front());
		end
	endtask

	// one bus cycle, driven on the falling edge
	task automatic cycle(input logic [15:0] a, input logic rd, input logic wr,
		input logic [7:0] d);
		@(negedge clk_sys);
		check_outputs();
		cart_addr = a;
		cart_rd   = rd;
		cart_wr   = wr;
		cart_di   = d;
		rom_q.push_back(rom_model(a)); // uses bank regs before this write
		if (rd && a[15:13] == `REGION_CRAM) begin
			rd_q.push_back(read_model(a));
			age_q.push_back(cyc);
		end
		if (wr)
			write_model(a, d);
		cyc++;
	endtask

	task automatic drain_reads();
		int n;
		n = 0;
		while (age_q.size() > 0 && n < 8) begin
			cycle(16'h0000, 1'b0, 1'b0, 8'h00);
			n++;
		end
		if (age_q.size() > 0) begin
			errors++;
			$display("pending reads never returned before reset at %0t", $time);
			age_q.delete();
			rd_q.delete();
		end
	endtask

	// header only moves while reset is high
	task automatic reset_dut(input int k, input logic [7:0] type_code,
		input logic [7:0] rom_code, input logic [7:0] ram_code);
		@(negedge clk_sys);
		check_outputs();
		reset         = 1'b1;
		cart_rd       = 1'b0;
		cart_wr       = 1'b0;
		cart_mbc_type = type_code;
		cart_rom_size = rom_code;
		cart_ram_size = ram_code;
		kind           = k;
		model_rom_mask = (rom_code <= 8'd8) ? 9'((2 << rom_code) - 1) : 9'h07F;
		model_ram_mask = (ram_code <= 8'd2) ? 4'h0 : ((ram_code == 8'd3) ? 4'h3 : 4'hF);
		model_rom_bank = 9'(`ROM_BANK_RESET);
		model_ram_bank = 4'd0;
		model_mode     = 1'b0;
		model_rtc      = 1'b0;
		model_ram_en   = 1'b0;
		rom_q.delete();
		written_q.delete();
		repeat (4) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------

	initial begin
		logic [7:0]  type_codes [5];
		logic [7:0]  rom_code;
		logic [15:0] a;
		logic [12:0] off;
		logic [2:0]  op;
		logic        w;
		type_codes = '{8'h00, 8'h03, 8'h06, 8'h10, 8'h1E}; // none, mbc1, mbc2, mbc3, mbc5
		reset         = 1'b1;
		cart_mbc_type = 8'h00;
		cart_rom_size = 8'h00;
		cart_ram_size = 8'h00;
		cart_addr     = 16'h0000;
		cart_rd       = 1'b0;
		cart_wr       = 1'b0;
		cart_di       = 8'h00;
		for (int k = 0; k < 5; k++) begin
			for (int s = 0; s < 13; s++) begin
				rom_code = (s < 9) ? 8'(s) : ((s < 12) ? 8'(8'h49 + s) : 8'hFF); // 52..54, junk
				reset_dut(k, type_codes[k], rom_code, 8'(s % 6));
				// fresh registers, region 1 must see bank 1
				for (int i = 0; i < 4; i++)
					cycle({2'b01, 14'(rand_bits(14))}, 1'b1, 1'b0, 8'h00);
				// bank register writes mixed with rom fetches
				for (int i = 0; i < 300; i++) begin
					a = {1'b0, 15'(rand_bits(15))};
					w = 1'(rand_bits(1));
					cycle(a, !w, w, 8'(rand_bits(8)));
				end
				// cart ram traffic, bank switching, lock and rtc select
				for (int i = 0; i < 300; i++) begin
					op  = 3'(rand_bits(3));
					off = 13'(rand_bits(13));
					if (rand_bits(1))
						off[12:9] = 4'd0; // mbc2 nibble window
					a = {`REGION_CRAM, off};
					case (op)
						3'd0, 3'd1: begin
							cycle(a, 1'b0, 1'b1, 8'(rand_bits(8)));
							written_q.push_back(a);
							if (written_q.size() > 64)
								void'(written_q.pop_front());
						end
						3'd2, 3'd3, 3'd4: begin
							if (written_q.size() > 0)
								a = written_q[rand_bits(8) % written_q.size()];
							cycle(a, 1'b1, 1'b0, 8'h00);
						end
						3'd5: cycle({`REGION_RAM_EN, off}, 1'b0, 1'b1,
							rand_bits(1) ? {4'(rand_bits(4)), `RAM_EN_KEY} : 8'(rand_bits(8)));
						3'd6: cycle({`REGION_RAM_BANK, off}, 1'b0, 1'b1, 8'(rand_bits(8)));
						default: cycle({`REGION_MODE, off}, 1'b0, 1'b1, 8'(rand_bits(8)));
					endcase
				end
				drain_reads();
			end
		end
		@(negedge clk_sys);
		check_outputs();
		$display("%0d errors in %0d checks", errors, checks);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule
